//--- fp_add_normaliser.sv
`timescale 1ns/1ps
`default_nettype none

`include "fpu_consts.svh"

module fp_add_normaliser (
  input  fpu_pkg::fp_exp_t  i_exp,
  input  fpu_pkg::fp_sum_t  i_man,
  output fpu_pkg::fp_exp_t  o_exp,
  output fpu_pkg::fp_sum_t  o_man
);
  import fpu_pkg::*;

  logic [4:0] shift;  // 1 to 20, or 0 when no one is found

  // Scan upward so the highest set bit sets the final shift
  always_comb begin
    shift = '0;
    for (int i = 3; i < `FP_FRAC_W; i++) begin
      if (i_man[i]) begin
        shift = 5'(`FP_FRAC_W - i);
      end
    end
  end

  assign o_man = i_man << shift;
  assign o_exp = i_exp - fp_exp_t'(shift);  // Wraps on underflow

endmodule

`default_nettype wire

//--- fp_adder.sv
`timescale 1ns/1ps
`default_nettype none

`include "fpu_consts.svh"

module fp_adder (
  input  fpu_pkg::fp_word_t  i_a,
  input  fpu_pkg::fp_word_t  i_b,
  output fpu_pkg::fp_word_t  o_sum
);
  import fpu_pkg::*;

  fp_fields_t fa, fb;
  fp_exp_t    ea, eb;
  fp_man_t    ma, mb;
  logic       a_big;
  logic       s_big;
  fp_exp_t    e_big, e_small, diff;
  fp_man_t    m_big, m_small, m_align;
  fp_sum_t    sum;
  fp_exp_t    norm_exp, res_exp;
  fp_sum_t    norm_man, res_man;
  logic       res_sign;

  assign fa = i_a;
  assign fb = i_b;

  // Subnormals count as exponent 1 with no hidden bit
  assign ea = (fa.exp == '0) ? fp_exp_t'(1) : fa.exp;
  assign eb = (fb.exp == '0) ? fp_exp_t'(1) : fb.exp;
  assign ma = {(fa.exp != '0), fa.frac};
  assign mb = {(fb.exp != '0), fb.frac};

  // Magnitude compare on exponent then mantissa
  assign a_big   = {ea, ma} >= {eb, mb};
  assign e_big   = a_big ? ea : eb;
  assign e_small = a_big ? eb : ea;
  assign m_big   = a_big ? ma : mb;
  assign m_small = a_big ? mb : ma;
  assign s_big   = a_big ? fa.sign : fb.sign;

  assign diff    = e_big - e_small;
  assign m_align = m_small >> diff;

  assign sum = (fa.sign == fb.sign) ? {1'b0, m_big} + {1'b0, m_align}
                                    : {1'b0, m_big} - {1'b0, m_align};

  fp_add_normaliser u_norm (
    .i_exp (e_big),
    .i_man (sum),
    .o_exp (norm_exp),
    .o_man (norm_man)
  );

  always_comb begin
    res_sign = s_big;
    if (sum == '0) begin
      res_sign = 1'b0;  // Exact cancellation gives +0
      res_exp  = '0;
      res_man  = '0;
    end else if (sum[`FP_FRAC_W+1]) begin
      res_exp = e_big + 1'b1;  // Carry-out
      res_man = sum >> 1;
    end else if (!sum[`FP_FRAC_W]) begin
      res_exp = norm_exp;
      res_man = norm_man;
    end else begin
      res_exp = e_big;
      res_man = sum;
    end
  end

  assign o_sum = {res_sign, res_exp, res_man[`FP_FRAC_W-1:0]};  // Truncated

endmodule

`default_nettype wire

//--- fp_multiplier.sv
`timescale 1ns/1ps
`default_nettype none

`include "fpu_consts.svh"

module fp_multiplier (
  input  fpu_pkg::fp_word_t  i_a,
  input  fpu_pkg::fp_word_t  i_b,
  output fpu_pkg::fp_word_t  o_p
);
  import fpu_pkg::*;

  localparam int P_TOP = 2*`FP_FRAC_W + 1;  // Product MSB

  fp_fields_t fa, fb;
  fp_exp_t    ea, eb, exp_sum, res_exp;
  fp_man_t    ma, mb;
  fp_prod_t   prod, res_prod;
  logic [2:0] shift;

  assign fa = i_a;
  assign fb = i_b;

  assign ea = (fa.exp == '0) ? fp_exp_t'(1) : fa.exp;
  assign eb = (fb.exp == '0) ? fp_exp_t'(1) : fb.exp;
  assign ma = {(fa.exp != '0), fa.frac};
  assign mb = {(fb.exp != '0), fb.frac};

  assign exp_sum = ea + eb - fp_exp_t'(`FP_BIAS);
  assign prod    = ma * mb;

  // Short shifter corrects at most 5 leading zeros
  always_comb begin
    casez (prod[P_TOP-1 -: 6])
      6'b01????: shift = 3'd1;
      6'b001???: shift = 3'd2;
      6'b0001??: shift = 3'd3;
      6'b00001?: shift = 3'd4;
      6'b000001: shift = 3'd5;
      default:   shift = 3'd0;
    endcase
  end

  always_comb begin
    if (prod[P_TOP]) begin
      res_exp  = exp_sum + 1'b1;
      res_prod = prod >> 1;
    end else if (!prod[P_TOP-1] && (exp_sum != '0)) begin
      res_exp  = exp_sum - fp_exp_t'(shift);
      res_prod = prod << shift;
    end else begin
      res_exp  = exp_sum;
      res_prod = prod;
    end
  end

  // Hidden bit sits at P_TOP-1 with the fraction below it
  assign o_p = {fa.sign ^ fb.sign, res_exp, res_prod[P_TOP-2 -: `FP_FRAC_W]};

endmodule

`default_nettype wire

//--- fp_special_cases.sv
`timescale 1ns/1ps
`default_nettype none

`include "fpu_consts.svh"

module fp_special_cases (
  input  fpu_pkg::fpu_cmd_t     i_cmd,
  output fpu_pkg::fp_special_t  o_special,
  output logic                  o_product_only
);
  import fpu_pkg::*;

  fp_fields_t fa, fb, fc;
  logic       a_nan, b_nan, c_nan;
  logic       a_inf, b_inf, c_inf;
  logic       a_zero, b_zero, c_zero;
  logic       xor_sign;

  function automatic fp_special_t take(fp_word_t value);
    return '{hit: 1'b1, value: value};
  endfunction

  function automatic fp_word_t inf_word(logic sign);
    return {sign, fp_exp_t'(`FP_EXP_MAX), {`FP_FRAC_W{1'b0}}};
  endfunction

  function automatic fp_word_t negate(fp_word_t w);
    return {~w[`FP_W-1], w[`FP_W-2:0]};
  endfunction

  assign fa = i_cmd.a;
  assign fb = i_cmd.b;
  assign fc = i_cmd.c;

  assign a_nan  = (fa.exp == fp_exp_t'(`FP_EXP_MAX)) && (fa.frac != '0);
  assign b_nan  = (fb.exp == fp_exp_t'(`FP_EXP_MAX)) && (fb.frac != '0);
  assign c_nan  = (fc.exp == fp_exp_t'(`FP_EXP_MAX)) && (fc.frac != '0);
  assign a_inf  = (fa.exp == fp_exp_t'(`FP_EXP_MAX)) && (fa.frac == '0);
  assign b_inf  = (fb.exp == fp_exp_t'(`FP_EXP_MAX)) && (fb.frac == '0);
  assign c_inf  = (fc.exp == fp_exp_t'(`FP_EXP_MAX)) && (fc.frac == '0);
  assign a_zero = (fa.exp == '0) && (fa.frac == '0);
  assign b_zero = (fb.exp == '0) && (fb.frac == '0);
  assign c_zero = (fc.exp == '0) && (fc.frac == '0);

  assign xor_sign = fa.sign ^ fb.sign;  // Also the product sign

  // First matching rule wins in each branch
  always_comb begin
    o_special      = '0;
    o_product_only = 1'b0;
    case (i_cmd.op)
      OP_FADD, OP_FSUB: begin
        if (a_nan || b_zero) begin
          o_special = take(i_cmd.a);
        end else if (b_nan || a_zero) begin
          o_special = take((i_cmd.op == OP_FSUB) ? negate(i_cmd.b) : i_cmd.b);
        end else if (a_inf || b_inf) begin
          o_special = take(inf_word(xor_sign));
        end
      end
      OP_FMUL: begin
        if (a_nan) begin
          o_special = take(i_cmd.a);
        end else if (b_nan) begin
          o_special = take(i_cmd.b);
        end else if (a_zero || b_zero) begin
          o_special = take({xor_sign, {(`FP_W-1){1'b0}}});  // Signed zero
        end else if (a_inf || b_inf) begin
          o_special = take(inf_word(xor_sign));
        end
      end
      OP_FMADD, OP_FMSUB: begin
        if (a_nan) begin
          o_special = take(i_cmd.a);
        end else if (b_nan) begin
          o_special = take(i_cmd.b);
        end else if (c_zero) begin
          o_product_only = 1'b1;  // Result is A*B alone
        end else if (a_zero || b_zero || c_nan) begin
          o_special = take((i_cmd.op == OP_FMSUB) ? negate(i_cmd.c) : i_cmd.c);
        end else if (a_inf || b_inf) begin
          o_special = take(inf_word(xor_sign));
        end else if (c_inf) begin
          o_special = take(inf_word(xor_sign ^ fc.sign));
        end
      end
      default: begin
        o_special = '0;
      end
    endcase
  end

endmodule

`default_nettype wire

//--- fpu_consts.svh
`ifndef FPU_CONSTS_SVH
`define FPU_CONSTS_SVH

// IEEE-754 binary32 field layout
`define FP_W        32
`define FP_EXP_W    8
`define FP_FRAC_W   23
`define FP_BIAS     127
`define FP_EXP_MAX  255   // NaN and infinity

// Wishbone byte addressing
`define WB_ADR_W    5

// Register map
`define REG_A       5'h00
`define REG_B       5'h04
`define REG_C       5'h08
`define REG_CMD     5'h0C
`define REG_RESULT  5'h10
`define REG_STATUS  5'h14

// Opcode field in the low bits of the command word
`define CMD_OP_W    3

`endif

//--- fpu_datapath.sv
`timescale 1ns/1ps
`default_nettype none

`include "fpu_consts.svh"

module fpu_datapath (
  input  logic                clk_i,
  input  logic                i_rst,
  input  fpu_pkg::fpu_cmd_t   i_cmd,
  input  logic                i_cmd_valid,
  output fpu_pkg::fp_word_t   o_res,
  output logic                o_res_valid
);
  import fpu_pkg::*;

  fp_special_t sc_special;
  logic        sc_prod_only;
  fp_word_t    mul_p;
  fp_word_t    addend;
  logic        sub_equal;

  // Stage 1
  logic        s1_valid;
  fpu_op_e     s1_op;
  fp_word_t    s1_a;
  fp_word_t    s1_prod;
  fp_word_t    s1_addend;
  fp_special_t s1_special;
  logic        s1_prod_only;
  logic        s1_sub_equal;

  // Stage 2
  fp_word_t    add_x;
  fp_word_t    add_sum;
  fp_word_t    res_next;

  fp_special_cases u_special (
    .i_cmd          (i_cmd),
    .o_special      (sc_special),
    .o_product_only (sc_prod_only)
  );

  fp_multiplier u_mul (
    .i_a (i_cmd.a),
    .i_b (i_cmd.b),
    .o_p (mul_p)
  );

  always_comb begin
    case (i_cmd.op)
      OP_FSUB:  addend = {~i_cmd.b[`FP_W-1], i_cmd.b[`FP_W-2:0]};
      OP_FMADD: addend = i_cmd.c;
      OP_FMSUB: addend = {~i_cmd.c[`FP_W-1], i_cmd.c[`FP_W-2:0]};
      default:  addend = i_cmd.b;
    endcase
  end

  assign sub_equal = (i_cmd.op == OP_FSUB) && (i_cmd.a == i_cmd.b);

  always_ff @(posedge clk_i) begin
    if (i_rst) begin
      s1_valid <= 1'b0;
    end else begin
      s1_valid <= i_cmd_valid;
    end
  end

  always_ff @(posedge clk_i) begin
    if (i_cmd_valid) begin
      s1_op        <= i_cmd.op;
      s1_a         <= i_cmd.a;
      s1_prod      <= mul_p;
      s1_addend    <= addend;
      s1_special   <= sc_special;
      s1_prod_only <= sc_prod_only;
      s1_sub_equal <= sub_equal;
    end
  end

  // Fused ops add to the product and plain add/sub use A
  assign add_x = (s1_op == OP_FMADD || s1_op == OP_FMSUB) ? s1_prod : s1_a;

  fp_adder u_add (
    .i_a   (add_x),
    .i_b   (s1_addend),
    .o_sum (add_sum)
  );

  always_comb begin
    if (s1_special.hit) begin
      res_next = s1_special.value;
    end else if (s1_sub_equal) begin
      res_next = '0;  // x - x is +0
    end else if (s1_op == OP_FMUL || s1_prod_only) begin
      res_next = s1_prod;
    end else begin
      res_next = add_sum;
    end
  end

  always_ff @(posedge clk_i) begin
    if (i_rst) begin
      o_res_valid <= 1'b0;
    end else begin
      o_res_valid <= s1_valid;
    end
  end

  always_ff @(posedge clk_i) begin
    if (s1_valid) begin
      o_res <= res_next;
    end
  end

  a_fixed_latency: assert property (@(posedge clk_i) disable iff (i_rst)
    i_cmd_valid |-> ##2 o_res_valid);
  a_no_spurious: assert property (@(posedge clk_i) disable iff (i_rst)
    o_res_valid |-> $past(i_cmd_valid, 2));

endmodule

`default_nettype wire

//--- fpu_pkg.sv
`default_nettype none

`include "fpu_consts.svh"

package fpu_pkg;

  typedef logic [`FP_W-1:0]          fp_word_t;
  typedef logic [`FP_EXP_W-1:0]      fp_exp_t;
  typedef logic [`FP_FRAC_W:0]       fp_man_t;   // Hidden bit on top
  typedef logic [`FP_FRAC_W+1:0]     fp_sum_t;   // Extra bit for carry-out
  typedef logic [2*`FP_FRAC_W+1:0]   fp_prod_t;

  typedef enum logic [`CMD_OP_W-1:0] {
    OP_FADD  = 0,
    OP_FSUB  = 1,
    OP_FMUL  = 2,
    OP_FMADD = 3,
    OP_FMSUB = 4
  } fpu_op_e;

  typedef struct packed {
    logic                   sign;
    fp_exp_t                exp;
    logic [`FP_FRAC_W-1:0]  frac;
  } fp_fields_t;

  typedef struct packed {
    fpu_op_e   op;
    fp_word_t  a;
    fp_word_t  b;
    fp_word_t  c;
  } fpu_cmd_t;

  // Fixed result of a NaN, zero or infinity case
  typedef struct packed {
    logic      hit;
    fp_word_t  value;
  } fp_special_t;

  typedef struct packed {
    logic                  cyc;
    logic                  stb;
    logic                  we;
    logic [`WB_ADR_W-1:0]  adr;
    fp_word_t              dat;
  } wb_req_t;

endpackage

`default_nettype wire

//--- fpu_top.sv
`timescale 1ns/1ps
`default_nettype none

module fpu_top (
  input  logic               clk_i,
  input  logic               i_rst,
  input  fpu_pkg::wb_req_t   i_wb,
  output fpu_pkg::fp_word_t  o_wb_dat,
  output logic               o_wb_ack
);
  import fpu_pkg::*;

  fpu_cmd_t cmd;
  logic     cmd_valid;
  fp_word_t res;
  logic     res_valid;

  fpu_wb_regs u_regs (
    .clk_i       (clk_i),
    .i_rst       (i_rst),
    .i_wb        (i_wb),
    .o_wb_dat    (o_wb_dat),
    .o_wb_ack    (o_wb_ack),
    .o_cmd       (cmd),
    .o_cmd_valid (cmd_valid),
    .i_res       (res),
    .i_res_valid (res_valid)
  );

  fpu_datapath u_datapath (
    .clk_i       (clk_i),
    .i_rst       (i_rst),
    .i_cmd       (cmd),
    .i_cmd_valid (cmd_valid),
    .o_res       (res),
    .o_res_valid (res_valid)
  );

endmodule

`default_nettype wire

//--- fpu_wb_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "fpu_consts.svh"

module fpu_wb_regs (
  input  logic               clk_i,
  input  logic               i_rst,
  input  fpu_pkg::wb_req_t   i_wb,
  output fpu_pkg::fp_word_t  o_wb_dat,
  output logic               o_wb_ack,
  output fpu_pkg::fpu_cmd_t  o_cmd,
  output logic               o_cmd_valid,
  input  fpu_pkg::fp_word_t  i_res,
  input  logic               i_res_valid
);
  import fpu_pkg::*;

  fp_word_t reg_a, reg_b, reg_c;
  fp_word_t reg_result;
  logic     busy, done, illegal, overrun;
  logic     bus_req, wr_req, rd_req;
  logic     cmd_wr, op_legal;
  fp_word_t rd_data;

  // New cycle seen before its ack
  assign bus_req = i_wb.cyc && i_wb.stb && !o_wb_ack;
  assign wr_req  = bus_req && i_wb.we;
  assign rd_req  = bus_req && !i_wb.we;

  assign cmd_wr   = wr_req && (i_wb.adr == `REG_CMD);
  assign op_legal = i_wb.dat[`CMD_OP_W-1:0] <= OP_FMSUB;

  // Starts on the edge that raises ack
  assign o_cmd_valid = cmd_wr && op_legal && !busy;
  assign o_cmd = '{op: fpu_op_e'(i_wb.dat[`CMD_OP_W-1:0]),
                   a:  reg_a,
                   b:  reg_b,
                   c:  reg_c};

  always_ff @(posedge clk_i) begin
    if (i_rst) begin
      o_wb_ack   <= 1'b0;
      busy       <= 1'b0;
      done       <= 1'b0;
      illegal    <= 1'b0;
      overrun    <= 1'b0;
      reg_result <= '0;
    end else begin
      o_wb_ack <= bus_req;  // Single-cycle ack
      if (o_cmd_valid) begin
        busy    <= 1'b1;
        done    <= 1'b0;
        illegal <= 1'b0;
        overrun <= 1'b0;
      end else if (cmd_wr && !op_legal) begin
        illegal <= 1'b1;
      end else if (cmd_wr) begin
        overrun <= 1'b1;  // Legal but dropped while busy
      end
      if (i_res_valid) begin
        busy       <= 1'b0;
        done       <= 1'b1;
        reg_result <= i_res;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_req) begin
      case (i_wb.adr)
        `REG_A:  reg_a <= i_wb.dat;
        `REG_B:  reg_b <= i_wb.dat;
        `REG_C:  reg_c <= i_wb.dat;
        default: ;
      endcase
    end
  end

  always_comb begin
    case (i_wb.adr)
      `REG_A:      rd_data = reg_a;
      `REG_B:      rd_data = reg_b;
      `REG_C:      rd_data = reg_c;
      `REG_RESULT: rd_data = reg_result;
      `REG_STATUS: rd_data = {{(`FP_W-4){1'b0}}, overrun, illegal, done, busy};
      default:     rd_data = '0;  // Command is write-only
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rd_req) begin
      o_wb_dat <= rd_data;
    end
  end

  a_ack_after_stb: assert property (@(posedge clk_i) disable iff (i_rst)
    o_wb_ack |-> $past(i_wb.cyc && i_wb.stb));
  a_res_when_busy: assert property (@(posedge clk_i) disable iff (i_rst)
    i_res_valid |-> busy);

endmodule

`default_nettype wire

//--- project.f
+incdir+.
fpu_pkg.sv
fp_special_cases.sv
fp_add_normaliser.sv
fp_adder.sv
fp_multiplier.sv
fpu_datapath.sv
fpu_wb_regs.sv
fpu_top.sv
tb_fpu.sv

//--- tb_fpu.sv
`timescale 1ns/1ps
`default_nettype none

`include "fpu_consts.svh"

module tb_fpu;
  import fpu_pkg::*;

  localparam int N_TESTS         = 6;
  localparam int WATCHDOG_CYCLES = 200 * N_TESTS * 2;
  localparam int ACK_LIMIT       = 16;  // Cycles to wait for a bus ack
  localparam int POLL_LIMIT      = 40;  // Status reads before giving up
  localparam int RAND_ROUNDS     = 4;

  logic     clk_i;
  logic     i_rst;
  wb_req_t  wb;
  fp_word_t o_wb_dat;
  logic     o_wb_ack;
  integer   seed;

  fpu_top dut_i (
    .clk_i    (clk_i),
    .i_rst    (i_rst),
    .i_wb     (wb),
    .o_wb_dat (o_wb_dat),
    .o_wb_ack (o_wb_ack)
  );

  always #5 clk_i = ~clk_i;

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Simulation finished: FAIL");
    $fatal(1);
  endtask

  task automatic check_val(input string name, input logic [31:0] got,
                           input logic [31:0] expected);
    if (got !== expected) begin
      abort_run($sformatf("mismatch %s: got 0x%08h expected 0x%08h", name, got, expected));
    end
  endtask

  // One classic cycle entered and left 1 ns after a rising edge
  task automatic wb_cycle(input logic we, input logic [`WB_ADR_W-1:0] adr,
                          input logic [31:0] wdata, output logic [31:0] rdata);
    int waits;
    wb.cyc = 1'b1;
    wb.stb = 1'b1;
    wb.we  = we;
    wb.adr = adr;
    wb.dat = wdata;
    @(posedge clk_i);
    #1;
    waits = 1;
    while (!o_wb_ack && waits < ACK_LIMIT) begin
      @(posedge clk_i);
      #1;
      waits++;
    end
    rdata = o_wb_dat;
    wb = '0;  // Drop stb in the cycle after ack
    if (!o_wb_ack) begin
      abort_run($sformatf("bus cycle at offset 0x%02h was never acknowledged", adr));
    end else begin
      @(posedge clk_i);
      #1;
    end
  endtask

  task automatic wb_write(input logic [`WB_ADR_W-1:0] adr, input logic [31:0] data);
    logic [31:0] unused;
    wb_cycle(1'b1, adr, data, unused);
  endtask

  task automatic wb_read(input logic [`WB_ADR_W-1:0] adr, output logic [31:0] data);
    wb_cycle(1'b0, adr, 32'h0, data);
  endtask

  task automatic wait_done(output logic [31:0] status);
    int polls;
    polls = 0;
    wb_read(`REG_STATUS, status);
    while (!status[1] && polls < POLL_LIMIT) begin
      wb_read(`REG_STATUS, status);
      polls++;
    end
    if (!status[1]) begin
      abort_run("done bit never set while polling status");
    end
  endtask

  task automatic run_op(input logic [2:0] op, input logic [31:0] a, input logic [31:0] b,
                        input logic [31:0] c, output logic [31:0] result,
                        output logic [31:0] status);
    wb_write(`REG_A, a);
    wb_write(`REG_B, b);
    wb_write(`REG_C, c);
    wb_write(`REG_CMD, {29'b0, op});
    wait_done(status);
    wb_read(`REG_RESULT, result);
  endtask

  // Full round trip that expects a clean done status
  task automatic check_op(input string name, input logic [2:0] op, input logic [31:0] a,
                          input logic [31:0] b, input logic [31:0] c,
                          input logic [31:0] expected);
    logic [31:0] result;
    logic [31:0] status;
    run_op(op, a, b, c, result, status);
    check_val("status", status, 32'h2);
    check_val(name, result, expected);
  endtask

  // Exact for the small integers used here
  function automatic logic [31:0] int_to_float(input int n);
    int          mag;
    int          msb;
    logic [31:0] m;
    mag = (n < 0) ? -n : n;
    msb = 0;
    for (int i = 0; i < 31; i++) begin
      if (mag[i]) msb = i;
    end
    m = mag;
    m = m << (23 - msb);
    if (mag == 0) return 32'h0;
    return {(n < 0), 8'(127 + msb), m[22:0]};
  endfunction

  task automatic test_reset_state();
    logic [31:0] data;
    wb_read(`REG_STATUS, data);
    check_val("status", data, 32'h0);
    wb_read(`REG_RESULT, data);
    check_val("result", data, 32'h0);
    wb_write(`REG_A, 32'h3F800000);
    wb_write(`REG_B, 32'hC1234567);
    wb_write(`REG_C, 32'h7F7FFFFF);
    wb_read(`REG_A, data);
    check_val("reg_a", data, 32'h3F800000);
    wb_read(`REG_B, data);
    check_val("reg_b", data, 32'hC1234567);
    wb_read(`REG_C, data);
    check_val("reg_c", data, 32'h7F7FFFFF);
    wb_read(5'h18, data);  // Unmapped offset
    check_val("unmapped", data, 32'h0);
  endtask

  task automatic test_illegal_opcode();
    logic [31:0] data;
    wb_write(`REG_CMD, 32'h5);
    repeat (4) @(posedge clk_i);  // Longer than the datapath latency
    #1;
    wb_read(`REG_STATUS, data);
    check_val("status", data, 32'h4);
    wb_read(`REG_RESULT, data);
    check_val("result", data, 32'h0);
  endtask

  task automatic test_normal_ops();
    int x, y, z;
    check_op("fadd", OP_FADD, 32'h3FC00000, 32'h40100000, 32'h0, 32'h40700000);
    check_op("fsub", OP_FSUB, 32'h40A00000, 32'h3FC00000, 32'h0, 32'h40600000);
    check_op("fmul", OP_FMUL, 32'h40400000, 32'hC0000000, 32'h0, 32'hC0C00000);
    check_op("fmadd", OP_FMADD, 32'h40000000, 32'h40400000, 32'h3F800000, 32'h40E00000);
    check_op("fmsub", OP_FMSUB, 32'h40000000, 32'h40400000, 32'h3F800000, 32'h40A00000);
    for (int i = 0; i < RAND_ROUNDS; i++) begin
      x = 1 + ({$random(seed)} % 15);
      y = 1 + ({$random(seed)} % 15);
      z = 1 + ({$random(seed)} % 15);
      check_op("fadd", OP_FADD, int_to_float(x), int_to_float(y), 32'h0,
               int_to_float(x + y));
      check_op("fsub", OP_FSUB, int_to_float(x), int_to_float(y), 32'h0,
               int_to_float(x - y));
      check_op("fmul", OP_FMUL, int_to_float(x), int_to_float(y), 32'h0,
               int_to_float(x * y));
      check_op("fmadd", OP_FMADD, int_to_float(x), int_to_float(y), int_to_float(z),
               int_to_float(x * y + z));
      check_op("fmsub", OP_FMSUB, int_to_float(x), int_to_float(y), int_to_float(z),
               int_to_float(x * y - z));
    end
  endtask

  task automatic test_special_cases();
    check_op("nan_add", OP_FADD, 32'h7FC12345, 32'h3F800000, 32'h0, 32'h7FC12345);
    check_op("inf_mul", OP_FMUL, 32'h7F800000, 32'h40000000, 32'h0, 32'h7F800000);
    check_op("zero_mul", OP_FMUL, 32'h00000000, 32'hC0400000, 32'h0, 32'h80000000);
    check_op("fmadd_c0", OP_FMADD, 32'h40000000, 32'h40400000, 32'h0, 32'h40C00000);
    check_op("fsub_eq", OP_FSUB, 32'h40400000, 32'h40400000, 32'h0, 32'h00000000);
  endtask

  task automatic test_busy_status();
    logic [31:0] data;
    wb_write(`REG_A, 32'h40000000);
    wb_write(`REG_B, 32'h40400000);
    wb_write(`REG_CMD, {29'b0, OP_FMUL});
    wb_read(`REG_STATUS, data);  // Lands before the result edge
    check_val("status.busy", {31'b0, data[0]}, 32'h1);
    wait_done(data);
    check_val("status", data, 32'h2);
    wb_read(`REG_RESULT, data);
    check_val("result", data, 32'h40C00000);
  endtask

  task automatic test_overrun();
    logic [31:0] data;
    wb_write(`REG_A, 32'h40000000);
    wb_write(`REG_B, 32'h40400000);
    wb_write(`REG_CMD, {29'b0, OP_FMUL});
    wb_write(`REG_CMD, {29'b0, OP_FADD});  // Dropped while the first one is in flight
    wait_done(data);
    check_val("status", data, 32'hA);
    wb_read(`REG_RESULT, data);
    check_val("result", data, 32'h40C00000);
  endtask

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk_i);
    abort_run($sformatf("run timed out after %0d cycles", WATCHDOG_CYCLES));
  end

  initial begin
    seed  = 73;
    clk_i = 1'b0;
    i_rst = 1'b1;
    wb    = '0;
    repeat (8) @(posedge clk_i);
    #1;
    i_rst = 1'b0;

    // Illegal check needs done still clear from reset
    test_reset_state();
    test_illegal_opcode();
    test_normal_ops();
    test_special_cases();
    test_busy_status();
    test_overrun();

    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

`default_nettype wire
